//--- ntm_params.svh
// NTM summation widths for data words and loop counters
`ifndef NTM_PARAMS_SVH
`define NTM_PARAMS_SVH

////////////////////////////////////////
// Data path
////////////////////////////////////////

// Width of data, modulo, size and length values
`define NTM_DATA_SIZE 32

////////////////////////////////////////
// Sequencing
////////////////////////////////////////

// Width of the row and element counters
// Must stay at or below NTM_DATA_SIZE
`define NTM_INDEX_SIZE 16

`endif

//--- ntm_pkg.sv
// NTM summation shared types for data words, counters and controller states
`include "ntm_params.svh"

package ntm_pkg;

  ////////////////////////////////////////
  // Data types
  ////////////////////////////////////////

  // Unsigned data word
  typedef logic [`NTM_DATA_SIZE-1:0] ntm_data_t;

  // Unsigned row and element counter
  typedef logic [`NTM_INDEX_SIZE-1:0] ntm_index_t;

  ////////////////////////////////////////
  // Controller FSM
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    starter,       // Idle, waiting for START
    input_vector,  // First element of a row
    input_scalar,  // Later element of the row
    ender          // Result pending from the scalar unit
  } vector_state_t;

endpackage

//--- ntm_scalar_sum_if.sv
// NTM scalar summation link between the vector controller and the modular accumulator
`timescale 1ns/100ps

interface ntm_scalar_sum_if;
  import ntm_pkg::*;

  // Controller to unit
  logic      start;
  logic      data_in_enable;
  ntm_data_t modulo;
  ntm_data_t length;
  ntm_data_t data_in;

  // Unit to controller
  logic      data_out_enable;
  logic      ready;
  ntm_data_t data_out;

  // Vector controller side
  modport ctrl (
    output start, data_in_enable, modulo, length, data_in,
    input  data_out_enable, ready, data_out
  );

  // Scalar summation side
  modport unit (
    input  start, data_in_enable, modulo, length, data_in,
    output data_out_enable, ready, data_out
  );

endinterface

//--- ntm_scalar_summation.sv
// NTM scalar summation unit, modular accumulator over one row with end-of-row flag
`timescale 1ns/100ps
`include "ntm_params.svh"

module ntm_scalar_summation (
  input logic            CLK,
  input logic            RST,
  ntm_scalar_sum_if.unit sum
);
  import ntm_pkg::*;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Running sum of the current row
  ntm_data_t acc;

  // Elements summed so far in the row
  ntm_index_t elem_count;
  ntm_index_t count_next;

  // Adder path, one extra bit for the carry
  ntm_data_t               base;
  logic [`NTM_DATA_SIZE:0] sum_wide;
  logic [`NTM_DATA_SIZE:0] sum_red;
  ntm_data_t               sum_mod;

  ////////////////////////////////////////
  // Modular adder
  ////////////////////////////////////////

  always_comb begin
    // First element of a row starts from zero
    base = sum.start ? '0 : acc;
    sum_wide = {1'b0, base} + {1'b0, sum.data_in};
    // Both operands below modulo, so one subtraction is enough
    if (sum_wide >= {1'b0, sum.modulo}) begin
      sum_red = sum_wide - {1'b0, sum.modulo};
    end else begin
      sum_red = sum_wide;
    end
    sum_mod = sum_red[`NTM_DATA_SIZE-1:0];
  end

  // Element count after this element
  always_comb begin
    if (sum.start) begin
      count_next = ntm_index_t'(1);
    end else begin
      count_next = elem_count + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      elem_count          <= '0;
      sum.data_out_enable <= 1'b0;
      sum.ready           <= 1'b0;
    end else begin
      // One-cycle answer to every element
      sum.data_out_enable <= sum.data_in_enable;
      sum.ready           <= 1'b0;
      if (sum.data_in_enable) begin
        elem_count <= count_next;
        // Last element of the row reached
        sum.ready  <= (ntm_data_t'(count_next) == sum.length);
      end
    end
  end

  ////////////////////////////////////////
  // Accumulator
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (sum.data_in_enable) begin
      acc <= sum_mod;
    end
  end

  // Partial sum straight from the accumulator
  assign sum.data_out = acc;

endmodule

//--- ntm_vector_summation.sv
// NTM vector summation controller, sequences rows and elements through the scalar unit
`timescale 1ns/100ps

module ntm_vector_summation (
  // Global
  input  logic                CLK,
  input  logic                RST,

  // Control
  input  logic                START,
  output logic                READY,
  input  logic                DATA_IN_VECTOR_ENABLE,
  input  logic                DATA_IN_SCALAR_ENABLE,
  output logic                DATA_OUT_VECTOR_ENABLE,
  output logic                DATA_OUT_SCALAR_ENABLE,

  // Data
  input  ntm_pkg::ntm_data_t  MODULO_IN,
  input  ntm_pkg::ntm_data_t  SIZE_IN,
  input  ntm_pkg::ntm_data_t  LENGTH_IN,
  input  ntm_pkg::ntm_data_t  DATA_IN,
  output ntm_pkg::ntm_data_t  DATA_OUT,

  // Scalar summation unit
  ntm_scalar_sum_if.ctrl      sum
);
  import ntm_pkg::*;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Controller FSM
  vector_state_t state;

  // Row currently being summed
  ntm_index_t row_index;

  // Element taken this cycle
  logic accept;
  logic accept_first;

  // Current row is the last one
  logic row_last;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  // Enables on the wrong line or while a result is pending drop out here
  assign accept_first = (state == input_vector) && DATA_IN_VECTOR_ENABLE;
  assign accept       = accept_first ||
                        ((state == input_scalar) && DATA_IN_SCALAR_ENABLE);

  assign row_last = (ntm_data_t'(row_index) == (SIZE_IN - ntm_data_t'(1)));

  ////////////////////////////////////////
  // FSM and output pulses
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state                  <= starter;
      row_index              <= '0;
      READY                  <= 1'b0;
      DATA_OUT_VECTOR_ENABLE <= 1'b0;
      DATA_OUT_SCALAR_ENABLE <= 1'b0;
      DATA_OUT               <= '0;
      sum.start              <= 1'b0;
      sum.data_in_enable     <= 1'b0;
    end else begin
      // All pulses last one cycle
      READY                  <= 1'b0;
      DATA_OUT_VECTOR_ENABLE <= 1'b0;
      DATA_OUT_SCALAR_ENABLE <= 1'b0;
      sum.start              <= 1'b0;
      sum.data_in_enable     <= 1'b0;

      case (state)
        starter: begin
          if (START) begin
            row_index <= '0;
            state     <= input_vector;
          end
        end
        input_vector: begin
          // First element clears the accumulator
          if (accept) begin
            sum.start          <= 1'b1;
            sum.data_in_enable <= 1'b1;
            state              <= ender;
          end
        end
        input_scalar: begin
          if (accept) begin
            sum.data_in_enable <= 1'b1;
            state              <= ender;
          end
        end
        ender: begin
          if (sum.data_out_enable) begin
            // Partial sum after every element
            DATA_OUT               <= sum.data_out;
            DATA_OUT_SCALAR_ENABLE <= 1'b1;
            if (sum.ready) begin
              // Row total
              DATA_OUT_VECTOR_ENABLE <= 1'b1;
              if (row_last) begin
                READY <= 1'b1;
                state <= starter;
              end else begin
                row_index <= row_index + 1'b1;
                state     <= input_vector;
              end
            end else begin
              state <= input_scalar;
            end
          end
        end
        default: begin
          state <= starter;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Operands toward the scalar unit
  ////////////////////////////////////////

  // Captured with each accepted element
  always_ff @(posedge CLK) begin
    if (accept) begin
      sum.modulo  <= MODULO_IN;
      sum.length  <= LENGTH_IN;
      sum.data_in <= DATA_IN;
    end
  end

endmodule

//--- ntm_vector_summation_top.sv
// NTM vector summation top level, controller plus scalar modular accumulator
`timescale 1ns/100ps

module ntm_vector_summation_top (
  // Global
  input  logic                CLK,
  input  logic                RST,

  // Control
  input  logic                START,
  output logic                READY,
  input  logic                DATA_IN_VECTOR_ENABLE,
  input  logic                DATA_IN_SCALAR_ENABLE,
  output logic                DATA_OUT_VECTOR_ENABLE,
  output logic                DATA_OUT_SCALAR_ENABLE,

  // Data
  input  ntm_pkg::ntm_data_t  MODULO_IN,
  input  ntm_pkg::ntm_data_t  SIZE_IN,
  input  ntm_pkg::ntm_data_t  LENGTH_IN,
  input  ntm_pkg::ntm_data_t  DATA_IN,
  output ntm_pkg::ntm_data_t  DATA_OUT
);

  // Controller to scalar unit link
  ntm_scalar_sum_if sum_if ();

  // Row and element sequencing
  ntm_vector_summation vector_summation_i (
    .CLK                    (CLK),
    .RST                    (RST),
    .START                  (START),
    .READY                  (READY),
    .DATA_IN_VECTOR_ENABLE  (DATA_IN_VECTOR_ENABLE),
    .DATA_IN_SCALAR_ENABLE  (DATA_IN_SCALAR_ENABLE),
    .DATA_OUT_VECTOR_ENABLE (DATA_OUT_VECTOR_ENABLE),
    .DATA_OUT_SCALAR_ENABLE (DATA_OUT_SCALAR_ENABLE),
    .MODULO_IN              (MODULO_IN),
    .SIZE_IN                (SIZE_IN),
    .LENGTH_IN              (LENGTH_IN),
    .DATA_IN                (DATA_IN),
    .DATA_OUT               (DATA_OUT),
    .sum                    (sum_if.ctrl)
  );

  // Modular accumulator
  ntm_scalar_summation scalar_summation_i (
    .CLK (CLK),
    .RST (RST),
    .sum (sum_if.unit)
  );

endmodule

//--- ntm_vector_summation_asserts.sv
// NTM vector summation output checks, pulse ordering and width on the top-level outputs
`timescale 1ns/100ps

module ntm_vector_summation_asserts (
  input logic CLK,
  input logic RST,
  input logic READY,
  input logic DATA_OUT_VECTOR_ENABLE,
  input logic DATA_OUT_SCALAR_ENABLE
);

  // Failure counts, one per assertion
  int unsigned ready_fails   = 0;
  int unsigned vector_fails  = 0;
  int unsigned ready_width   = 0;
  int unsigned vector_width  = 0;
  int unsigned scalar_width  = 0;
  int unsigned fail_count;

  assign fail_count = ready_fails + vector_fails + ready_width + vector_width + scalar_width;

  ////////////////////////////////////////
  // Pulse ordering
  ////////////////////////////////////////

  // End of operation only with a row total
  ready_has_vector: assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_VECTOR_ENABLE)
    else begin
      $error("READY without DATA_OUT_VECTOR_ENABLE");
      ready_fails = ready_fails + 1;
    end

  // Row total is also a partial sum
  vector_has_scalar: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_VECTOR_ENABLE |-> DATA_OUT_SCALAR_ENABLE)
    else begin
      $error("DATA_OUT_VECTOR_ENABLE without DATA_OUT_SCALAR_ENABLE");
      vector_fails = vector_fails + 1;
    end

  ////////////////////////////////////////
  // Pulse width
  ////////////////////////////////////////

  ready_one_cycle: assert property (@(posedge CLK) disable iff (RST)
    READY |=> !READY)
    else begin
      $error("READY high for more than one cycle");
      ready_width = ready_width + 1;
    end

  vector_one_cycle: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_VECTOR_ENABLE |=> !DATA_OUT_VECTOR_ENABLE)
    else begin
      $error("DATA_OUT_VECTOR_ENABLE high for more than one cycle");
      vector_width = vector_width + 1;
    end

  scalar_one_cycle: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_SCALAR_ENABLE |=> !DATA_OUT_SCALAR_ENABLE)
    else begin
      $error("DATA_OUT_SCALAR_ENABLE high for more than one cycle");
      scalar_width = scalar_width + 1;
    end

endmodule

//--- ntm_vector_summation_tb.sv
// NTM vector summation testbench running directed and random rows against a modular sum model
`timescale 1ns/100ps

module ntm_vector_summation_tb;
  import ntm_pkg::*;

  // About four cycles per element over all tests plus margin
  localparam int TIMEOUT_CYCLES = 2000;
  // Longest wait for one result pulse
  localparam int RESULT_WAIT    = 10;
  localparam int RANDOM_OPS     = 8;

  logic      CLK;
  logic      RST;
  logic      START;
  logic      READY;
  logic      DATA_IN_VECTOR_ENABLE;
  logic      DATA_IN_SCALAR_ENABLE;
  logic      DATA_OUT_VECTOR_ENABLE;
  logic      DATA_OUT_SCALAR_ENABLE;
  ntm_data_t MODULO_IN;
  ntm_data_t SIZE_IN;
  ntm_data_t LENGTH_IN;
  ntm_data_t DATA_IN;
  ntm_data_t DATA_OUT;

  int          error_count  = 0;
  int          check_count  = 0;
  int          cycle_count  = 0;
  int          last_latency = 0;
  logic [31:0] lcg_state    = 32'h12d835eb;

  // Running row sum of the reference model
  ntm_data_t model_sum;
  // Elements of one operation
  ntm_data_t elems[$];

  ntm_vector_summation_top dut_i (
    .CLK                    (CLK),
    .RST                    (RST),
    .START                  (START),
    .READY                  (READY),
    .DATA_IN_VECTOR_ENABLE  (DATA_IN_VECTOR_ENABLE),
    .DATA_IN_SCALAR_ENABLE  (DATA_IN_SCALAR_ENABLE),
    .DATA_OUT_VECTOR_ENABLE (DATA_OUT_VECTOR_ENABLE),
    .DATA_OUT_SCALAR_ENABLE (DATA_OUT_SCALAR_ENABLE),
    .MODULO_IN              (MODULO_IN),
    .SIZE_IN                (SIZE_IN),
    .LENGTH_IN              (LENGTH_IN),
    .DATA_IN                (DATA_IN),
    .DATA_OUT               (DATA_OUT)
  );

  bind ntm_vector_summation_top ntm_vector_summation_asserts asserts_i (
    .CLK                    (CLK),
    .RST                    (RST),
    .READY                  (READY),
    .DATA_OUT_VECTOR_ENABLE (DATA_OUT_VECTOR_ENABLE),
    .DATA_OUT_SCALAR_ENABLE (DATA_OUT_SCALAR_ENABLE)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Run limit
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout, run still going after %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic ntm_data_t next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // (previous + element) mod modulo in 64 bits so no carry is lost
  function automatic ntm_data_t model_add(ntm_data_t acc, ntm_data_t elem, ntm_data_t modulo);
    logic [63:0] total;
    total = {32'd0, acc} + {32'd0, elem};
    return ntm_data_t'(total % {32'd0, modulo});
  endfunction

  task automatic check_data(input string name, input ntm_data_t expected, input ntm_data_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_drive_point();
    @(posedge CLK);
    #1;
  endtask

  // No output pulse for n cycles
  task automatic watch_quiet(input int n);
    repeat (n) begin
      @(negedge CLK);
      check_flag("DATA_OUT_SCALAR_ENABLE", 1'b0, DATA_OUT_SCALAR_ENABLE);
      check_flag("DATA_OUT_VECTOR_ENABLE", 1'b0, DATA_OUT_VECTOR_ENABLE);
      check_flag("READY", 1'b0, READY);
    end
  endtask

  task automatic start_operation(input ntm_data_t size, input ntm_data_t length,
                                 input ntm_data_t modulo);
    next_drive_point();
    SIZE_IN   = size;
    LENGTH_IN = length;
    MODULO_IN = modulo;
    START     = 1'b1;
    next_drive_point();
    START     = 1'b0;
  endtask

  // One element in and its partial sum and flags out
  task automatic send_element(input logic first, input ntm_data_t value, input logic exp_vector,
                              input logic exp_ready, input logic noise);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    if (noise) begin
      // Wrong line for the current state
      next_drive_point();
      DATA_IN               = ~value;
      DATA_IN_VECTOR_ENABLE = !first;
      DATA_IN_SCALAR_ENABLE = first;
      next_drive_point();
      DATA_IN_VECTOR_ENABLE = 1'b0;
      DATA_IN_SCALAR_ENABLE = 1'b0;
      watch_quiet(4);
    end
    next_drive_point();
    DATA_IN               = value;
    DATA_IN_VECTOR_ENABLE = first;
    DATA_IN_SCALAR_ENABLE = !first;
    next_drive_point();
    DATA_IN_VECTOR_ENABLE = 1'b0;
    DATA_IN_SCALAR_ENABLE = 1'b0;
    if (noise) begin
      // Both lines while the result is pending
      DATA_IN               = ~value;
      DATA_IN_VECTOR_ENABLE = 1'b1;
      DATA_IN_SCALAR_ENABLE = 1'b1;
      next_drive_point();
      DATA_IN_VECTOR_ENABLE = 1'b0;
      DATA_IN_SCALAR_ENABLE = 1'b0;
    end
    while (!seen && cycles < RESULT_WAIT) begin
      @(negedge CLK);
      cycles++;
      seen = DATA_OUT_SCALAR_ENABLE;
    end
    last_latency = cycles;
    if (!seen) begin
      error_count++;
      $display("No partial sum pulse within %0d cycles of element %0d", RESULT_WAIT, value);
    end else begin
      check_data("DATA_OUT", model_sum, DATA_OUT);
      check_flag("DATA_OUT_VECTOR_ENABLE", exp_vector, DATA_OUT_VECTOR_ENABLE);
      check_flag("READY", exp_ready, READY);
    end
  endtask

  // Walks elems row by row
  task automatic run_operation(input ntm_data_t size, input ntm_data_t length,
                               input ntm_data_t modulo, input logic noise);
    int idx;
    idx = 0;
    start_operation(size, length, modulo);
    for (int row = 0; row < int'(size); row++) begin
      for (int col = 0; col < int'(length); col++) begin
        model_sum = model_add((col == 0) ? ntm_data_t'(0) : model_sum, elems[idx], modulo);
        send_element(col == 0, elems[idx], col == int'(length) - 1,
                     (col == int'(length) - 1) && (row == int'(size) - 1), noise);
        idx++;
      end
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_reset();
    watch_quiet(1);
    check_data("DATA_OUT", ntm_data_t'(0), DATA_OUT);
  endtask

  task automatic test_single_element();
    elems.delete();
    elems.push_back(ntm_data_t'(42));
    run_operation(1, 1, 100, 1'b0);
    if (last_latency != 3) begin
      error_count++;
      $display("Single element result came %0d cycles after its enable, not 3", last_latency);
    end
  endtask

  // Partial sums 9 3 2 7 5
  task automatic test_modular_wrap();
    elems.delete();
    elems.push_back(ntm_data_t'(9));
    elems.push_back(ntm_data_t'(7));
    elems.push_back(ntm_data_t'(12));
    elems.push_back(ntm_data_t'(5));
    elems.push_back(ntm_data_t'(11));
    run_operation(1, 5, 13, 1'b0);
  endtask

  task automatic test_multiple_rows();
    elems.delete();
    repeat (12) elems.push_back(next_random() % 32'd1000);
    run_operation(3, 4, 1000, 1'b0);
  endtask

  task automatic test_ignored_enables();
    // Idle with START not given yet
    next_drive_point();
    DATA_IN               = 32'd77;
    DATA_IN_VECTOR_ENABLE = 1'b1;
    next_drive_point();
    DATA_IN_VECTOR_ENABLE = 1'b0;
    DATA_IN_SCALAR_ENABLE = 1'b1;
    next_drive_point();
    DATA_IN_SCALAR_ENABLE = 1'b0;
    watch_quiet(6);
    elems.delete();
    repeat (6) elems.push_back(next_random() % 32'd50);
    run_operation(2, 3, 50, 1'b1);
  endtask

  task automatic test_random_operations();
    ntm_data_t r;
    ntm_data_t modulo;
    ntm_data_t size;
    ntm_data_t length;
    for (int op = 0; op < RANDOM_OPS; op++) begin
      r = next_random();
      // Small modulo wraps often while a large one exercises the carry
      modulo = r[0] ? 32'd2 + (r % 32'd100) : (r | 32'h8000_0000);
      size   = 32'd1 + next_random() % 32'd4;
      length = 32'd1 + next_random() % 32'd6;
      elems.delete();
      repeat (int'(size * length)) elems.push_back(next_random() % modulo);
      run_operation(size, length, modulo, 1'b0);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    RST                   = 1'b1;
    START                 = 1'b0;
    DATA_IN_VECTOR_ENABLE = 1'b0;
    DATA_IN_SCALAR_ENABLE = 1'b0;
    MODULO_IN             = '0;
    SIZE_IN               = '0;
    LENGTH_IN             = '0;
    DATA_IN               = '0;
    model_sum             = '0;
    repeat (2) @(posedge CLK);
    #1;
    RST = 1'b0;

    test_reset();
    test_single_element();
    test_modular_wrap();
    test_multiple_rows();
    test_ignored_enables();
    test_random_operations();
    watch_quiet(4);

    $display("Errors: %0d in %0d checks, assertion failures: %0d",
             error_count, check_count, dut_i.asserts_i.fail_count);
    if (error_count == 0 && dut_i.asserts_i.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+.
ntm_pkg.sv
ntm_scalar_sum_if.sv
ntm_scalar_summation.sv
ntm_vector_summation.sv
ntm_vector_summation_top.sv
ntm_vector_summation_asserts.sv
ntm_vector_summation_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert -f verilog.f \
		--top-module ntm_vector_summation_tb -Mdir obj_dir
	-./obj_dir/Vntm_vector_summation_tb +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^All checks passed$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
